/* alu_pkg.sv */
package alu_pkg;

	//3 bit ALU control, 001 and 111 stay unassigned
	typedef enum logic [2:0] {
		op_pass = 3'b000,
		op_add  = 3'b010,
		op_sub  = 3'b011,
		op_and  = 3'b100,
		op_or   = 3'b101,
		op_xor  = 3'b110
	} alu_op_e;

	//overflow sits in the top bit so it maps straight onto status[7:4]
	typedef struct packed {
		logic overflow;
		logic negative;
		logic zero;
		logic carry_out;
	} alu_flags_t;

	//register form, fmt = 0
	typedef struct packed {
		alu_op_e     op;
		logic        fmt;
		logic [4:0]  rd;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [12:0] rsvd;
	} cmd_rr_t;

	//immediate form, fmt = 1
	//imm is sign extended to 64 bits and used as B
	typedef struct packed {
		alu_op_e     op;
		logic        fmt;
		logic [4:0]  rd;
		logic [4:0]  ra;
		logic [15:0] imm;
		logic [1:0]  rsvd;
	} cmd_ri_t;

	//one command word, op/fmt/rd/ra line up in both views
	typedef union packed {
		cmd_rr_t rr;
		cmd_ri_t ri;
	} cmd_u;

endpackage

/* bus_pkg.sv */
package bus_pkg;

	//AXI4-Lite payloads
	//valid and ready run as separate ports beside them
	typedef struct packed {
		logic [11:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [31:0] data;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [11:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	//register file request
	//half_en bit 0 is the low word and bit 1 the high word
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [1:0]  half_en;
		logic [63:0] wdata;
	} rf_req_t;

	//register n low word at 8n and high word at 8n+4
	localparam logic [11:0] reg_base    = 12'h000;
	localparam logic [11:0] cmd_addr    = 12'h100;
	localparam logic [11:0] status_addr = 12'h104;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic [63:0]         a,
	input  logic [63:0]         b,
	input  alu_pkg::alu_op_e    op,
	output logic [63:0]         result,
	output alu_pkg::alu_flags_t flags
);

	//subtract selects ~b plus a carry in of one
	logic sub;

	//add or sub, the only ops that report carry and overflow
	logic arith;

	//b as seen by the adder
	logic [63:0] b_adj;

	//65 bits so the carry out falls into the top bit
	logic [64:0] sum;

	assign sub   = (op == alu_pkg::op_sub);
	assign arith = (op == alu_pkg::op_add) || sub;
	assign b_adj = sub ? ~b : b;

	//two's complement stage 2 through the carry in
	assign sum = {1'b0, a} + {1'b0, b_adj} + {64'd0, sub};

	//op selector
	always_comb begin
		case (op)
			alu_pkg::op_pass: result = b;
			alu_pkg::op_add:  result = sum[63:0];
			alu_pkg::op_sub:  result = sum[63:0];
			alu_pkg::op_and:  result = a & b;
			alu_pkg::op_or:   result = a | b;
			alu_pkg::op_xor:  result = a ^ b;
			//illegal codes give zero, the sequencer never writes them back
			default:          result = '0;
		endcase
	end

	//carry out of bit 63
	assign flags.carry_out = arith & sum[64];

	//signed overflow
	//operands agree in sign and the sum does not
	assign flags.overflow = arith & (a[63] == b_adj[63]) & (sum[63] != a[63]);

	//sign only has meaning on a subtract
	assign flags.negative = sub & result[63];

	assign flags.zero = (result == '0);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic             clk,
	input  logic             rst,
	input  bus_pkg::rf_req_t req,
	input  logic             valid,
	output logic [63:0]      rdata
);

	//32 x 64 storage
	logic [63:0] mem [32];

	//each half has its own write enable
	always_ff @(posedge clk) begin
		if (valid && req.we) begin
			if (req.half_en[0])
				mem[req.addr][31:0] <= req.wdata[31:0];
			if (req.half_en[1])
				mem[req.addr][63:32] <= req.wdata[63:32];
		end
	end

	//read data shows up one cycle after the granted request
	always_ff @(posedge clk) begin
		if (rst)
			rdata <= '0;
		else if (valid)
			rdata <= mem[req.addr];
	end

endmodule

/* reg_arbiter.sv */
`timescale 1ns/1ps

module reg_arbiter #(
	parameter int num_req = 2
) (
	input  logic                             clk,
	input  logic                             rst,
	input  bus_pkg::rf_req_t [num_req-1:0]   reqs,
	input  logic [num_req-1:0]               req_valid,
	output logic [num_req-1:0]               gnt,
	output logic [num_req-1:0]               rdata_valid,
	output bus_pkg::rf_req_t                 out_req,
	output logic                             out_valid
);

	localparam int ptr_w = (num_req > 1) ? $clog2(num_req) : 1;

	//requester with the highest priority this cycle
	logic [ptr_w-1:0] ptr;

	//winner of the search
	logic [ptr_w-1:0] sel;
	logic             found;

	//search from ptr upward and wrap
	always_comb begin
		int idx;
		gnt   = '0;
		sel   = ptr;
		found = 1'b0;
		for (int i = 0; i < num_req; i++) begin
			idx = (int'(ptr) + i) % num_req;
			if (!found && req_valid[idx]) begin
				found = 1'b1;
				sel   = ptr_w'(idx);
			end
		end
		if (found)
			gnt[sel] = 1'b1;
	end

	assign out_req   = reqs[sel];
	assign out_valid = found;

	//rotate past the winner
	//the grant is delayed one cycle to tag the read data
	always_ff @(posedge clk) begin
		if (rst) begin
			ptr         <= '0;
			rdata_valid <= '0;
		end else begin
			rdata_valid <= gnt;
			if (found)
				ptr <= ptr_w'((int'(sel) + 1) % num_req);
		end
	end

	a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

	//a grant never lands on an idle requester, so read data is never mistagged
	a_gnt_valid: assert property (@(posedge clk) disable iff (rst)
		(gnt & ~req_valid) == '0);

endmodule

/* axil_host_port.sv */
`timescale 1ns/1ps

module axil_host_port (
	input  logic                clk,
	input  logic                rst,
	input  bus_pkg::axil_aw_t   aw,
	input  logic                awvalid,
	output logic                awready,
	input  bus_pkg::axil_w_t    w,
	input  logic                wvalid,
	output logic                wready,
	output bus_pkg::axil_b_t    b,
	output logic                bvalid,
	input  logic                bready,
	input  bus_pkg::axil_ar_t   ar,
	input  logic                arvalid,
	output logic                arready,
	output bus_pkg::axil_r_t    r,
	output logic                rvalid,
	input  logic                rready,
	output bus_pkg::rf_req_t    rf_req,
	output logic                rf_req_valid,
	input  logic                rf_gnt,
	input  logic                rf_rdata_valid,
	input  logic [63:0]         rf_rdata,
	output logic                cmd_valid,
	output alu_pkg::cmd_u       cmd,
	input  logic                busy,
	input  logic                done,
	input  logic                illegal,
	input  alu_pkg::alu_flags_t flags
);

	typedef enum logic [2:0] {s_idle, s_rf, s_rd_wait, s_bresp, s_rresp} state_e;
	state_e state;

	logic wr_take;
	logic rd_take;
	logic wr_reg;
	logic rd_reg;
	logic cmd_ok;
	logic seq_busy;
	logic rd_hi;
	logic st_illegal;
	alu_pkg::alu_flags_t st_flags;
	logic [31:0] status_word;
	logic [31:0] rd_local;
	logic [1:0] wr_resp;
	logic [1:0] rd_resp;

	//write needs aw and w together and wins over a read
	assign wr_take = (state == s_idle) && awvalid && wvalid;
	assign rd_take = (state == s_idle) && arvalid && !(awvalid && wvalid);
	assign awready = wr_take;
	assign wready  = wr_take;
	assign arready = rd_take;

	//register area is the first 256 bytes
	assign wr_reg = (aw.addr[11:8] == bus_pkg::reg_base[11:8]);
	assign rd_reg = (ar.addr[11:8] == bus_pkg::reg_base[11:8]);

	//covers the gap between the cmd pulse and busy, and the done cycle
	assign seq_busy = busy | cmd_valid | done;
	assign cmd_ok   = (aw.addr == bus_pkg::cmd_addr) && !seq_busy;

	//flags in 7:4, illegal in 1, busy in 0
	assign status_word = {24'd0, st_flags, 2'b00, st_illegal, seq_busy};

	//status is read only
	assign wr_resp = (wr_reg || cmd_ok) ? bus_pkg::resp_okay : bus_pkg::resp_slverr;

	always_comb begin
		rd_local = '0;
		rd_resp  = bus_pkg::resp_okay;
		if (ar.addr == bus_pkg::status_addr)
			rd_local = status_word;
		else if (ar.addr == bus_pkg::cmd_addr)
			rd_local = cmd;
		else if (!rd_reg)
			rd_resp = bus_pkg::resp_slverr;
	end

	assign rf_req_valid = (state == s_rf);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= s_idle;
			bvalid     <= 1'b0;
			rvalid     <= 1'b0;
			cmd_valid  <= 1'b0;
			st_illegal <= 1'b0;
			st_flags   <= '0;
		end else begin
			cmd_valid <= 1'b0;
			//sticky until the next command finishes
			if (done) begin
				st_illegal <= illegal;
				st_flags   <= flags;
			end
			case (state)
				s_idle: begin
					if (wr_take && wr_reg) begin
						state <= s_rf;
					end else if (wr_take) begin
						cmd_valid <= cmd_ok;
						bvalid    <= 1'b1;
						state     <= s_bresp;
					end else if (rd_take && rd_reg) begin
						state <= s_rf;
					end else if (rd_take) begin
						rvalid <= 1'b1;
						state  <= s_rresp;
					end
				end
				//hold the request until the arbiter grants it
				s_rf: begin
					if (rf_gnt && rf_req.we) begin
						bvalid <= 1'b1;
						state  <= s_bresp;
					end else if (rf_gnt) begin
						state <= s_rd_wait;
					end
				end
				s_rd_wait: begin
					if (rf_rdata_valid) begin
						rvalid <= 1'b1;
						state  <= s_rresp;
					end
				end
				s_bresp: begin
					if (bready) begin
						bvalid <= 1'b0;
						state  <= s_idle;
					end
				end
				s_rresp: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	//payload
	always_ff @(posedge clk) begin
		if (wr_take) begin
			rf_req.we      <= 1'b1;
			rf_req.addr    <= aw.addr[7:3];
			rf_req.half_en <= aw.addr[2] ? 2'b10 : 2'b01;
			rf_req.wdata   <= {w.data, w.data};
			b.resp         <= wr_resp;
			if (cmd_ok)
				cmd <= w.data;
		end else if (rd_take) begin
			rf_req.we      <= 1'b0;
			rf_req.addr    <= ar.addr[7:3];
			rf_req.half_en <= 2'b00;
			rd_hi          <= ar.addr[2];
			r.data         <= rd_local;
			r.resp         <= rd_resp;
		end else if (state == s_rd_wait && rf_rdata_valid) begin
			//pick the addressed word
			r.data <= rd_hi ? rf_rdata[63:32] : rf_rdata[31:0];
		end
	end

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(b));

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(r));

endmodule

/* alu_sequencer.sv */
`timescale 1ns/1ps

module alu_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                cmd_valid,
	input  alu_pkg::cmd_u       cmd,
	output bus_pkg::rf_req_t    rf_req,
	output logic                rf_req_valid,
	input  logic                rf_gnt,
	input  logic                rf_rdata_valid,
	input  logic [63:0]         rf_rdata,
	output logic                busy,
	output logic                done,
	output logic                illegal,
	output alu_pkg::alu_flags_t flags,
	output logic [63:0]         alu_a,
	output logic [63:0]         alu_b,
	output alu_pkg::alu_op_e    alu_op,
	input  logic [63:0]         alu_result,
	input  alu_pkg::alu_flags_t alu_flags
);

	typedef enum logic [2:0] {q_idle, q_read_a, q_read_b, q_exec, q_write} state_e;
	state_e state;

	//granted, read data due next cycle
	logic wait_data;
	logic data_in;
	logic op_ok;
	alu_pkg::cmd_u cmd_q;
	logic [63:0] res_q;

	//001 and 111 fall to default
	always_comb begin
		case (cmd.rr.op)
			alu_pkg::op_pass,
			alu_pkg::op_add,
			alu_pkg::op_sub,
			alu_pkg::op_and,
			alu_pkg::op_or,
			alu_pkg::op_xor: op_ok = 1'b1;
			default:         op_ok = 1'b0;
		endcase
	end

	assign busy    = (state != q_idle);
	assign data_in = wait_data && rf_rdata_valid;
	assign alu_op  = cmd_q.rr.op;

	//reads use ra then rb, the write goes to rd with both halves
	assign rf_req_valid = ((state == q_read_a || state == q_read_b) && !wait_data)
		|| (state == q_write);
	assign rf_req.we      = (state == q_write);
	assign rf_req.addr    = (state == q_read_a) ? cmd_q.rr.ra :
		(state == q_read_b) ? cmd_q.rr.rb : cmd_q.rr.rd;
	assign rf_req.half_en = (state == q_write) ? 2'b11 : 2'b00;
	assign rf_req.wdata   = res_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= q_idle;
			wait_data <= 1'b0;
			done      <= 1'b0;
			illegal   <= 1'b0;
			flags     <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				q_idle: begin
					//illegal op finishes at once with nothing written
					if (cmd_valid && op_ok) begin
						illegal <= 1'b0;
						state   <= q_read_a;
					end else if (cmd_valid) begin
						illegal <= 1'b1;
						flags   <= '0;
						done    <= 1'b1;
					end
				end
				q_read_a, q_read_b: begin
					if (rf_gnt)
						wait_data <= 1'b1;
					//immediate form skips the B read
					if (data_in) begin
						wait_data <= 1'b0;
						state <= (state == q_read_a && !cmd_q.rr.fmt) ? q_read_b : q_exec;
					end
				end
				q_exec: begin
					flags <= alu_flags;
					state <= q_write;
				end
				q_write: begin
					if (rf_gnt) begin
						done  <= 1'b1;
						state <= q_idle;
					end
				end
				default: state <= q_idle;
			endcase
		end
	end

	//operands and result
	always_ff @(posedge clk) begin
		if (state == q_idle && cmd_valid)
			cmd_q <= cmd;
		if (state == q_read_a && data_in) begin
			alu_a <= rf_rdata;
			if (cmd_q.ri.fmt)
				alu_b <= {{48{cmd_q.ri.imm[15]}}, cmd_q.ri.imm};
		end
		if (state == q_read_b && data_in)
			alu_b <= rf_rdata;
		if (state == q_exec)
			res_q <= alu_result;
	end

	a_idle_no_req: assert property (@(posedge clk) disable iff (rst)
		state == q_idle |-> !rf_req_valid);

	//the host port only issues a command once the last one is done
	a_cmd_when_idle: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> state == q_idle && !done);

endmodule

/* alu_subsys_top.sv */
`timescale 1ns/1ps

module alu_subsys_top (
	input  logic              clk,
	input  logic              rst,
	input  bus_pkg::axil_aw_t aw,
	input  logic              awvalid,
	output logic              awready,
	input  bus_pkg::axil_w_t  w,
	input  logic              wvalid,
	output logic              wready,
	output bus_pkg::axil_b_t  b,
	output logic              bvalid,
	input  logic              bready,
	input  bus_pkg::axil_ar_t ar,
	input  logic              arvalid,
	output logic              arready,
	output bus_pkg::axil_r_t  r,
	output logic              rvalid,
	input  logic              rready
);

	localparam int num_req = 2;

	//requester 0 is the host port, 1 the sequencer
	bus_pkg::rf_req_t [num_req-1:0] arb_reqs;
	logic [num_req-1:0] req_valid;
	logic [num_req-1:0] gnt;
	logic [num_req-1:0] rdata_valid;

	bus_pkg::rf_req_t rf_req;
	logic rf_valid;
	logic [63:0] rf_rdata;

	//host port to sequencer
	logic cmd_valid;
	alu_pkg::cmd_u cmd;
	logic busy;
	logic done;
	logic illegal;
	alu_pkg::alu_flags_t flags;

	//sequencer to ALU
	logic [63:0] alu_a;
	logic [63:0] alu_b;
	logic [63:0] alu_result;
	alu_pkg::alu_op_e alu_op;
	alu_pkg::alu_flags_t alu_flags;

	axil_host_port u_host (
		.*,
		.rf_req(arb_reqs[0]),
		.rf_req_valid(req_valid[0]),
		.rf_gnt(gnt[0]),
		.rf_rdata_valid(rdata_valid[0])
	);

	alu_sequencer u_seq (
		.*,
		.rf_req(arb_reqs[1]),
		.rf_req_valid(req_valid[1]),
		.rf_gnt(gnt[1]),
		.rf_rdata_valid(rdata_valid[1])
	);

	reg_arbiter #(
		.num_req(num_req)
	) u_arb (
		.clk(clk),
		.rst(rst),
		.reqs(arb_reqs),
		.req_valid(req_valid),
		.gnt(gnt),
		.rdata_valid(rdata_valid),
		.out_req(rf_req),
		.out_valid(rf_valid)
	);

	reg_file u_rf (
		.clk(clk),
		.rst(rst),
		.req(rf_req),
		.valid(rf_valid),
		.rdata(rf_rdata)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.result(alu_result),
		.flags(alu_flags)
	);

endmodule

/* tb_alu_subsys.sv */
`timescale 1ns/1ps

module tb_alu_subsys;

	localparam int max_vec = 64;
	localparam int cycles_per_vector = 400;
	// round trip, busy and unmapped tests counted as extra vectors
	localparam int extra_steps = 8;

	logic clk;
	logic rst;
	bus_pkg::axil_aw_t aw;
	logic awvalid;
	logic awready;
	bus_pkg::axil_w_t w;
	logic wvalid;
	logic wready;
	bus_pkg::axil_b_t b;
	logic bvalid;
	logic bready;
	bus_pkg::axil_ar_t ar;
	logic arvalid;
	logic arready;
	bus_pkg::axil_r_t r;
	logic rvalid;
	logic rready;

	// vector table
	logic v_fmt [max_vec];
	logic [2:0] v_op [max_vec];
	logic [4:0] v_rd [max_vec];
	logic [4:0] v_ra [max_vec];
	logic [15:0] v_imm [max_vec];
	logic [63:0] v_a [max_vec];
	logic [63:0] v_b [max_vec];
	logic [63:0] v_res [max_vec];
	logic [3:0] v_flags [max_vec];
	int n_vec;

	int max_delay;
	int rnd;
	int cycle_count = 0;
	int timeout_limit = cycles_per_vector * extra_steps;

	alu_subsys_top u_dut (
		.clk(clk),
		.rst(rst),
		.aw(aw),
		.awvalid(awvalid),
		.awready(awready),
		.w(w),
		.wvalid(wvalid),
		.wready(wready),
		.b(b),
		.bvalid(bvalid),
		.bready(bready),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rvalid(rvalid),
		.rready(rready)
	);

	always #50 clk = ~clk;

	// run length guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", timeout_limit);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	task check(input logic [63:0] actual, input logic [63:0] expected, input string msg);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// one AXI4-Lite write, aw and w together
	task write_word(input logic [11:0] addr, input logic [31:0] data, output logic [1:0] resp);
		int delay;
		@(negedge clk);
		aw.addr = addr;
		w.data = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		while (!awready) begin
			@(negedge clk);
			#1;
		end
		check(wready, 1'b1, "wready together with awready");
		// handshake taken at the coming rising edge
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		delay = $urandom % (max_delay + 1);
		repeat (delay) @(negedge clk);
		bready = 1'b1;
		resp = b.resp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task read_word(input logic [11:0] addr, output logic [31:0] data, output logic [1:0] resp);
		int delay;
		@(negedge clk);
		ar.addr = addr;
		arvalid = 1'b1;
		#1;
		while (!arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		// rvalid has to hold through the stall
		delay = $urandom % (max_delay + 1);
		repeat (delay) @(negedge clk);
		rready = 1'b1;
		data = r.data;
		resp = r.resp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// 64 bit register as two word writes, low word first
	task store_reg(input int n, input logic [63:0] value);
		logic [1:0] resp;
		write_word(bus_pkg::reg_base + 12'(n * 8), value[31:0], resp);
		check(resp, bus_pkg::resp_okay, $sformatf("reg %0d low write response", n));
		write_word(bus_pkg::reg_base + 12'(n * 8 + 4), value[63:32], resp);
		check(resp, bus_pkg::resp_okay, $sformatf("reg %0d high write response", n));
	endtask

	task fetch_reg(input int n, output logic [63:0] value);
		logic [1:0] resp;
		read_word(bus_pkg::reg_base + 12'(n * 8), value[31:0], resp);
		check(resp, bus_pkg::resp_okay, $sformatf("reg %0d low read response", n));
		read_word(bus_pkg::reg_base + 12'(n * 8 + 4), value[63:32], resp);
		check(resp, bus_pkg::resp_okay, $sformatf("reg %0d high read response", n));
	endtask

	// status until busy clears
	task poll_idle(output logic [31:0] status);
		logic [1:0] resp;
		status = 32'h1;
		while (status[0]) begin
			read_word(bus_pkg::status_addr, status, resp);
			check(resp, bus_pkg::resp_okay, "status read response");
		end
	endtask

	// columns: fmt op rd ra rb_or_imm a b result flags, all hex
	task load_vectors();
		int fd;
		int code;
		int n;
		string line;
		logic f;
		logic [2:0] op;
		logic [4:0] rd;
		logic [4:0] ra;
		logic [15:0] rbi;
		logic [63:0] a;
		logic [63:0] bv;
		logic [63:0] res;
		logic [3:0] fl;
		n_vec = 0;
		fd = $fopen("alu_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open alu_vectors.txt");
			$display("** FAIL **");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			// comment and blank lines give fewer than nine fields
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f, op, rd, ra, rbi, a, bv, res, fl);
			if (code > 0 && n == 9 && n_vec < max_vec) begin
				v_fmt[n_vec] = f;
				v_op[n_vec] = op;
				v_rd[n_vec] = rd;
				v_ra[n_vec] = ra;
				v_imm[n_vec] = rbi;
				v_a[n_vec] = a;
				v_b[n_vec] = bv;
				v_res[n_vec] = res;
				v_flags[n_vec] = fl;
				n_vec++;
			end
		end
		$fclose(fd);
		if (n_vec == 0) begin
			$display("alu_vectors.txt holds no usable vector lines");
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task run_vector(input int i);
		logic bad_op;
		logic [31:0] cmd_word;
		logic [31:0] status;
		logic [63:0] result;
		logic [1:0] resp;
		// 001 and 111 are undefined codes
		bad_op = (v_op[i] == 3'b001) || (v_op[i] == 3'b111);
		store_reg(v_ra[i], v_a[i]);
		if (!v_fmt[i])
			store_reg(v_imm[i][4:0], v_b[i]);
		// op, fmt, rd, ra, then rb or the 16 bit imm
		if (v_fmt[i])
			cmd_word = {v_op[i], 1'b1, v_rd[i], v_ra[i], v_imm[i], 2'b00};
		else
			cmd_word = {v_op[i], 1'b0, v_rd[i], v_ra[i], v_imm[i][4:0], 13'd0};
		write_word(bus_pkg::cmd_addr, cmd_word, resp);
		check(resp, bus_pkg::resp_okay, $sformatf("vector %0d cmd response", i));
		poll_idle(status);
		check(status[1], bad_op, $sformatf("vector %0d illegal bit", i));
		check(status[7:4], v_flags[i], $sformatf("vector %0d flags", i));
		fetch_reg(v_rd[i], result);
		check(result, v_res[i], $sformatf("vector %0d result in r%0d", i, v_rd[i]));
	endtask

	// busy rejection plus host writes racing the sequencer
	task contention_test();
		logic [63:0] a;
		logic [63:0] bv;
		logic [63:0] result;
		logic [63:0] fill [8];
		logic [31:0] status;
		logic [1:0] resp;
		// back to back transfers keep the second cmd inside the busy window
		max_delay = 0;
		a = {$urandom, $urandom};
		bv = {$urandom, $urandom};
		store_reg(20, a);
		store_reg(21, bv);
		write_word(bus_pkg::cmd_addr, {3'b010, 1'b0, 5'd22, 5'd20, 5'd21, 13'd0}, resp);
		check(resp, bus_pkg::resp_okay, "add cmd response");
		write_word(bus_pkg::cmd_addr, {3'b110, 1'b0, 5'd22, 5'd20, 5'd21, 13'd0}, resp);
		check(resp, bus_pkg::resp_slverr, "cmd written while busy");
		for (int k = 0; k < 8; k++) begin
			fill[k] = {$urandom, $urandom};
			store_reg(24 + k, fill[k]);
		end
		poll_idle(status);
		check(status[1], 1'b0, "illegal bit after add");
		fetch_reg(22, result);
		check(result, a + bv, "add result under contention");
		for (int k = 0; k < 8; k++) begin
			fetch_reg(24 + k, result);
			check(result, fill[k], $sformatf("filler reg %0d", 24 + k));
		end
		max_delay = 3;
	endtask

	initial begin
		logic [63:0] rt [4];
		logic [63:0] value;
		logic [31:0] word;
		logic [1:0] resp;
		rnd = $urandom(32'hdc54);
		clk = 1'b0;
		rst = 1'b1;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		max_delay = 3;
		load_vectors();
		timeout_limit = cycles_per_vector * (n_vec + extra_steps);
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// status clear out of reset
		read_word(bus_pkg::status_addr, word, resp);
		check(word, 32'd0, "status after reset");

		// round trip on r16 to r19
		for (int k = 0; k < 4; k++) begin
			rt[k] = {$urandom, $urandom};
			store_reg(16 + k, rt[k]);
		end
		for (int k = 0; k < 4; k++) begin
			fetch_reg(16 + k, value);
			check(value, rt[k], $sformatf("round trip r%0d", 16 + k));
		end
		// single half writes leave the other half alone
		write_word(bus_pkg::reg_base + 12'(16 * 8), 32'h0badf00d, resp);
		check(resp, bus_pkg::resp_okay, "low half write response");
		fetch_reg(16, value);
		check(value, {rt[0][63:32], 32'h0badf00d}, "low half only on r16");
		write_word(bus_pkg::reg_base + 12'(17 * 8 + 4), 32'hc0ffee11, resp);
		check(resp, bus_pkg::resp_okay, "high half write response");
		fetch_reg(17, value);
		check(value, {32'hc0ffee11, rt[1][31:0]}, "high half only on r17");

		for (int i = 0; i < n_vec; i++)
			run_vector(i);

		contention_test();

		// unmapped space
		write_word(12'h200, 32'h1234, resp);
		check(resp, bus_pkg::resp_slverr, "write to 0x200");
		write_word(12'h108, 32'h1234, resp);
		check(resp, bus_pkg::resp_slverr, "write to 0x108");
		read_word(12'h300, word, resp);
		check(resp, bus_pkg::resp_slverr, "read from 0x300");

		$display("** PASS **");
		$finish;
	end

endmodule

/* alu_vectors.txt */
# fmt op rd ra rb_or_imm a b expected_result expected_flags (overflow negative zero carry_out)
# all hex, immediate rows hold the 16 bit imm in column 5 and its sign extension as b
0 0 03 01 02 1111111111111111 123456789abcdef0 123456789abcdef0 0
0 0 04 05 06 ffffffffffffffff 0000000000000000 0000000000000000 2
0 2 07 08 09 0000000000000005 0000000000000007 000000000000000c 0
0 2 0a 0b 0c ffffffffffffffff 0000000000000001 0000000000000000 3
0 2 0d 0e 0f 7fffffffffffffff 0000000000000001 8000000000000000 8
0 2 10 11 12 8000000000000000 8000000000000000 0000000000000000 b
0 3 13 14 15 000000000000000a 0000000000000003 0000000000000007 1
0 3 16 17 00 0000000000000003 000000000000000a fffffffffffffff9 4
0 3 01 02 03 123456789abcdef0 123456789abcdef0 0000000000000000 3
0 3 04 05 06 8000000000000000 0000000000000001 7fffffffffffffff 9
0 4 07 08 09 ff00ff00ff00ff00 0ff00ff00ff00ff0 0f000f000f000f00 0
0 4 0a 0b 0c aaaaaaaaaaaaaaaa 5555555555555555 0000000000000000 2
0 5 0d 0e 0f ff00ff00ff00ff00 0ff00ff00ff00ff0 fff0fff0fff0fff0 0
0 6 10 11 12 ff00ff00ff00ff00 0ff00ff00ff00ff0 f0f0f0f0f0f0f0f0 0
0 6 13 14 15 deadbeefcafef00d deadbeefcafef00d 0000000000000000 2
1 2 16 17 0010 0000000000000100 0000000000000010 0000000000000110 0
1 2 01 02 fff0 0000000000000100 fffffffffffffff0 00000000000000f0 1
1 3 03 04 ffff 0000000000000005 ffffffffffffffff 0000000000000006 0
1 3 05 06 0001 0000000000000000 0000000000000001 ffffffffffffffff 4
1 0 07 08 8000 0000000000000000 ffffffffffff8000 ffffffffffff8000 0
1 6 09 0a 7fff 00000000ffffffff 0000000000007fff 00000000ffff8000 0
0 1 0b 0b 0c 0123456789abcdef 0000000000000001 0123456789abcdef 0
1 7 0d 0d 0005 fedcba9876543210 0000000000000005 fedcba9876543210 0

/* compile.f */
alu_pkg.sv
bus_pkg.sv
alu.sv
reg_file.sv
reg_arbiter.sv
axil_host_port.sv
alu_sequencer.sv
alu_subsys_top.sv
tb_alu_subsys.sv
